//--- include/tapMac_defs.svh
/*
 * Width and repetition constants of the stream tap MAC.
 * TAP_ACC_W covers frames of up to 256 beats at TAP_REP = 3.
 * Overflow is not detected.
 * TAP_IDX_W must hold TAP_REP - 1. TAP_REP must be at least 1.
 */
`ifndef TAPMAC_DEFS_SVH
`define TAPMAC_DEFS_SVH

`define TAP_DATA_W 16 // Signed sample width.
`define TAP_COEF_W 8 // Signed coefficient width.
`define TAP_ACC_W 40 // Accumulator and result width.
`define TAP_REP 3 // Tap repetitions of every beat.
`define TAP_IDX_W 2 // Repetition index and coefficient address width.

`endif

//--- hw/tapMacPkg.sv
/*
 * Shared stream and control types of the stream tap MAC.
 * Field widths come from the defines header.
 */
`default_nettype none

`include "tapMac_defs.svh"

package tapMacPkg;

	// One stream beat. It is used on the input, forward and tap streams.
	typedef struct packed {
		logic signed [`TAP_DATA_W-1:0] data; // Signed sample.
		logic last; // Marks the final beat of a frame.
	} tapBeat_t;

	// Coefficient write port. Addresses of TAP_REP and above are dropped.
	typedef struct packed {
		logic we; // Write strobe, one cycle per write.
		logic [`TAP_IDX_W-1:0] addr; // Repetition slot to replace.
		logic signed [`TAP_COEF_W-1:0] data; // New coefficient.
	} coefWrite_t;

	// Per-cycle commands from the control FSM to the MAC datapath.
	typedef struct packed {
		logic accEn; // A tap transfer happens this cycle.
		logic frameEnd; // That transfer closes the frame.
	} macCtrl_t;

endpackage : tapMacPkg

`default_nettype wire

//--- hw/streamTap.sv
/*
 * Stream tap. Every input beat goes out once on the forward stream and
 * TAP_REP times in a row on the tap stream.
 * A sidestep register keeps the input ready for one extra beat while the
 * output stage is still held, so inReady only drops a cycle later.
 * The output stage reloads only once both copies of its beat are gone.
 */
`timescale 1ns/1ps
`default_nettype none

module streamTap import tapMacPkg::*; #(
	parameter int TAP_REP = 1 // Tap repetitions per beat, at least 1.
) (
	input logic clk,
	input logic rst,

	input tapBeat_t inBeat,
	input logic inValid,
	output logic inReady,

	output tapBeat_t fwdBeat,
	output logic fwdValid,
	input logic fwdReady,

	output tapBeat_t tapBeat,
	output logic tapValid,
	input logic tapReady
);

	// One spare bit so that -TAP_REP is negative and counting up to zero ends it.
	localparam int CNT_W = 1 + $clog2(TAP_REP);

	typedef logic signed [CNT_W-1:0] repCnt_t;

	tapBeat_t sideBeat; // Sidestep register payload.
	logic sideValid; // Sidestep register holds a beat.

	tapBeat_t outBeat; // Output register, shared by both outputs.
	logic fwdPending; // Forward copy not yet taken.
	repCnt_t repCnt; // Runs from -TAP_REP up to zero. The sign bit is tap valid.
	logic repFinal; // The next tap transfer is the final repetition.

	logic avail; // A beat is offered from the sidestep register or the input.
	logic tapTick; // Tap transfer in this cycle.
	logic reload; // The output register takes a new beat (or goes empty).
	repCnt_t repNext; // Counter after this cycle's tap transfer.

	assign inReady = !sideValid; // Only the sidestep register can block the input.
	assign fwdBeat = outBeat;
	assign fwdValid = fwdPending;
	assign tapBeat = outBeat;
	assign tapValid = repCnt[CNT_W-1];

	assign avail = sideValid || inValid;
	assign tapTick = tapValid && tapReady;
	assign repNext = repCnt + repCnt_t'(tapTick);

	// The stage is free once the forward copy has gone and the tap has taken
	// its final repetition, including both in this very cycle.
	assign reload = (fwdReady || !fwdPending) && ((tapTick && repFinal) || !tapValid);

	// Payload registers.
	always_ff @(posedge clk) begin
		if (inReady) begin
			sideBeat <= inBeat; // Captured every free cycle, used only if the stage is busy.
		end
		if (reload) begin
			outBeat <= sideValid ? sideBeat : inBeat; // The older beat goes first.
		end
	end

	// Occupancy and repetition state.
	always_ff @(posedge clk) begin
		if (rst) begin
			sideValid <= 1'b0;
			fwdPending <= 1'b0;
			repCnt <= '0; // Zero keeps the sign bit, and thus tapValid, low.
			repFinal <= 1'b0;
		end else begin
			sideValid <= avail && !reload; // Park the beat when the stage cannot take it.
			if (reload) begin
				fwdPending <= avail;
				repCnt <= avail ? repCnt_t'(-TAP_REP) : repCnt_t'(0);
				repFinal <= avail && (TAP_REP == 1); // A single repetition is final at once.
			end else begin
				fwdPending <= fwdPending && !fwdReady;
				repCnt <= repNext;
				repFinal <= (repNext == repCnt_t'(-1)); // Look one transfer ahead.
			end
		end
	end

endmodule : streamTap

`default_nettype wire

//--- hw/coefBank.sv
/*
 * Coefficient registers, one per tap repetition, read by repetition index.
 * Reset loads 1 into every slot. Writes show on the read port one cycle later.
 * Writes to addresses of TAP_REP or above are dropped. Reads there return zero.
 * Do not write while a frame is in flight.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tapMac_defs.svh"

module coefBank import tapMacPkg::*; (
	input logic clk,
	input logic rst,

	input coefWrite_t coefWr,

	input logic [`TAP_IDX_W-1:0] repIdx,
	output logic signed [`TAP_COEF_W-1:0] coef
);

	localparam logic signed [`TAP_COEF_W-1:0] COEF_ONE = 1; // Unity gain.

	logic signed [`TAP_COEF_W-1:0] coefReg [`TAP_REP]; // One coefficient per repetition.

	logic wrHit; // The write addresses an existing slot.

	assign wrHit = coefWr.we && (coefWr.addr < `TAP_REP);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `TAP_REP; i++) begin
				coefReg[i] <= COEF_ONE; // Plain repetition sum until programmed.
			end
		end else if (wrHit) begin
			coefReg[coefWr.addr] <= coefWr.data;
		end
	end

	// Combinational read so that the coefficient lines up with its tap beat.
	always_comb begin
		if (repIdx < `TAP_REP) begin
			coef = coefReg[repIdx];
		end else begin
			coef = '0; // Unused index.
		end
	end

endmodule : coefBank

`default_nettype wire

//--- hw/macUnit.sv
/*
 * Multiply-accumulate datapath with a frame result register.
 * Every accEn adds sample times coefficient to the accumulator.
 * On frameEnd the complete sum, this cycle's product included, moves to
 * the result register and the accumulator starts over from zero.
 * There is no overflow check. TAP_ACC_W is sized for frames up to 256 beats.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tapMac_defs.svh"

module macUnit import tapMacPkg::*; (
	input logic clk,
	input logic rst,

	input tapBeat_t sample,
	input logic signed [`TAP_COEF_W-1:0] coef,
	input macCtrl_t macCtrl,

	output logic signed [`TAP_ACC_W-1:0] result
);

	logic signed [`TAP_DATA_W+`TAP_COEF_W-1:0] product; // Full precision product.
	logic signed [`TAP_ACC_W-1:0] acc; // Running frame sum.
	logic signed [`TAP_ACC_W-1:0] accSum; // Sum including this cycle's product.

	assign product = $signed(sample.data) * coef; // Both signed, so no extension loss.
	assign accSum = acc + product; // Product is sign-extended to the accumulator width.

	always_ff @(posedge clk) begin
		if (rst) begin
			acc <= '0;
			result <= '0;
		end else begin
			if (macCtrl.frameEnd) begin
				result <= accSum; // Valid one cycle after frameEnd, with resValid.
				acc <= '0; // The next frame starts clean.
			end else if (macCtrl.accEn) begin
				acc <= accSum;
			end
		end
	end

endmodule : macUnit

`default_nettype wire

//--- hw/tapMacControl.sv
/*
 * Control of the tap MAC. It counts tap transfers modulo TAP_REP, flags
 * the end of a frame and owns the result valid flag.
 * Only the transfer that would close a frame waits while an unread result
 * is still held. Other repetitions keep flowing into the accumulator.
 * The repetition count stays aligned with the tap since both start at reset.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tapMac_defs.svh"

module tapMacControl import tapMacPkg::*; (
	input logic clk,
	input logic rst,

	input tapBeat_t tapBeat,
	input logic tapValid,
	output logic tapReady,

	output logic [`TAP_IDX_W-1:0] repIdx,
	output macCtrl_t macCtrl,

	output logic resValid,
	input logic resReady
);

	localparam logic [`TAP_IDX_W-1:0] LAST_IDX = `TAP_REP - 1; // Final repetition.

	logic tapTick; // A tap transfer happens this cycle.
	logic finalRep; // The offered beat is on its final repetition.
	logic closesFrame; // The offered transfer would end the frame.
	logic resFree; // The result register may be overwritten next cycle.

	assign finalRep = (repIdx == LAST_IDX);
	assign closesFrame = finalRep && tapBeat.last;
	assign resFree = !resValid || resReady; // Empty, or read out right now.

	// Hold off only a frame end that would overwrite an unread result.
	assign tapReady = resFree || !closesFrame;
	assign tapTick = tapValid && tapReady;

	assign macCtrl.accEn = tapTick; // Every tap transfer adds a product.
	assign macCtrl.frameEnd = tapTick && closesFrame;

	// Repetition index, wraps after TAP_REP transfers.
	always_ff @(posedge clk) begin
		if (rst) begin
			repIdx <= '0;
		end else if (tapTick) begin
			repIdx <= finalRep ? '0 : repIdx + 1'b1;
		end
	end

	// Result valid rises with the result register and holds until taken.
	always_ff @(posedge clk) begin
		if (rst) begin
			resValid <= 1'b0;
		end else if (macCtrl.frameEnd) begin
			resValid <= 1'b1; // A new result replaces one that is read now.
		end else if (resReady) begin
			resValid <= 1'b0;
		end
	end

endmodule : tapMacControl

`default_nettype wire

//--- hw/streamTapMac.sv
/*
 * Top level of the stream tap with weighted repetition accumulator.
 * The input stream is forwarded unchanged. Its tapped copy is repeated
 * TAP_REP times, weighted by coefficient k on repetition k and summed
 * over a frame into one result.
 * Back-pressure on the forward or result stream stalls the input.
 * Coefficients must not be written while a frame is in flight.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tapMac_defs.svh"

module streamTapMac import tapMacPkg::*; (
	input logic clk,
	input logic rst,

	input tapBeat_t inBeat,
	input logic inValid,
	output logic inReady,

	output tapBeat_t fwdBeat,
	output logic fwdValid,
	input logic fwdReady,

	output logic signed [`TAP_ACC_W-1:0] result,
	output logic resValid,
	input logic resReady,

	input coefWrite_t coefWr
);

	tapBeat_t tapBeat; // Tapped beat, repeated TAP_REP times.
	logic tapValid;
	logic tapReady;

	logic [`TAP_IDX_W-1:0] repIdx; // Repetition of the current tap beat.
	macCtrl_t macCtrl; // Accumulate and frame end strobes.
	logic signed [`TAP_COEF_W-1:0] coef; // Weight of the current repetition.

	streamTap #(
		.TAP_REP(`TAP_REP)
	) u_streamTap (
		.clk(clk),
		.rst(rst),
		.inBeat(inBeat),
		.inValid(inValid),
		.inReady(inReady),
		.fwdBeat(fwdBeat),
		.fwdValid(fwdValid),
		.fwdReady(fwdReady),
		.tapBeat(tapBeat),
		.tapValid(tapValid),
		.tapReady(tapReady)
	);

	tapMacControl u_tapMacControl (
		.clk(clk),
		.rst(rst),
		.tapBeat(tapBeat),
		.tapValid(tapValid),
		.tapReady(tapReady),
		.repIdx(repIdx),
		.macCtrl(macCtrl),
		.resValid(resValid),
		.resReady(resReady)
	);

	coefBank u_coefBank (
		.clk(clk),
		.rst(rst),
		.coefWr(coefWr),
		.repIdx(repIdx),
		.coef(coef)
	);

	macUnit u_macUnit (
		.clk(clk),
		.rst(rst),
		.sample(tapBeat),
		.coef(coef),
		.macCtrl(macCtrl),
		.result(result)
	);

endmodule : streamTapMac

`default_nettype wire

//--- verification/tapMacScoreboard.sv
/*
 * Reference model and checker of the stream tap MAC.
 * All handshakes are sampled at the falling clock edge, where every port
 * has settled. The coefficient model follows the write port. It assumes
 * that writes only happen while no frame is in flight.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tapMac_defs.svh"

module tapMacScoreboard import tapMacPkg::*; (
	input logic clk,
	input logic rst,
	input tapBeat_t inBeat,
	input logic inValid,
	input logic inReady,
	input tapBeat_t fwdBeat,
	input logic fwdValid,
	input logic fwdReady,
	input logic signed [`TAP_ACC_W-1:0] result,
	input logic resValid,
	input logic resReady,
	input coefWrite_t coefWr,
	output int fwdErrors,
	output int resErrors,
	output int fwdLeft,
	output int resLeft
);

	tapBeat_t fwdQ[$]; // Accepted beats still owed on the forward stream.
	longint resQ[$]; // Expected frame sums, oldest first.
	longint coefModel [`TAP_REP]; // Mirror of the coefficient bank.
	longint frameData; // Data sum of the frame that is still open.

	// Every beat meets every coefficient once, so a frame sum factors.
	function automatic longint coefSum();
		longint sum;
		sum = 0;
		for (int k = 0; k < `TAP_REP; k++) begin
			sum += coefModel[k];
		end
		return sum;
	endfunction

	initial begin
		fwdErrors = 0;
		resErrors = 0;
		fwdLeft = 0;
		resLeft = 0;
	end

	always @(negedge clk) begin
		tapBeat_t expBeat;
		longint expRes;
		if (rst) begin
			fwdQ.delete();
			resQ.delete();
			frameData = 0;
			for (int k = 0; k < `TAP_REP; k++) begin
				coefModel[k] = 1; // Unity after reset.
			end
		end else begin
			if (coefWr.we && (coefWr.addr < `TAP_REP)) begin
				coefModel[coefWr.addr] = $signed(coefWr.data); // Unused addresses drop.
			end
			if (fwdValid && fwdReady) begin
				assert (fwdQ.size() != 0) else begin
					$display("At %0t ns the forward stream sent a beat that was never put in.",
						$time);
					fwdErrors++;
				end
				if (fwdQ.size() != 0) begin
					expBeat = fwdQ.pop_front();
					assert (fwdBeat == expBeat) else begin
						$display("Error at %0t ns: forward beat %0d/%0b, expected %0d/%0b.", $time,
							$signed(fwdBeat.data), fwdBeat.last, $signed(expBeat.data), expBeat.last);
						fwdErrors++;
					end
				end
			end
			if (resValid && resReady) begin
				assert (resQ.size() != 0) else begin
					$display("At %0t ns the result stream sent a result for no open frame.",
						$time);
					resErrors++;
				end
				if (resQ.size() != 0) begin
					expRes = resQ.pop_front();
					assert (longint'(result) == expRes) else begin
						$display("Error at %0t ns: result %0d, expected %0d.", $time,
							result, expRes);
						resErrors++;
					end
				end
			end
			// Inputs are pushed last. Outputs never carry a beat of the same edge.
			if (inValid && inReady) begin
				fwdQ.push_back(inBeat);
				frameData += $signed(inBeat.data);
				if (inBeat.last) begin
					resQ.push_back(frameData * coefSum()); // Frame closes here.
					frameData = 0;
				end
			end
		end
		fwdLeft = fwdQ.size();
		resLeft = resQ.size();
	end

endmodule : tapMacScoreboard

`default_nettype wire

//--- verification/tb_streamTapMac.sv
/*
 * Testbench of the stream tap MAC. Random frames from a fixed seed run
 * through unity coefficients, programmed coefficients under back-pressure,
 * single-beat and 256-beat frames, and a second programming.
 * Coefficients are only written once both streams have drained.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tapMac_defs.svh"

module tb_streamTapMac import tapMacPkg::*; ();

	localparam int CLK_PERIOD = 4; // Clock period in ns.
	localparam int UNITY_BEATS = 120;
	localparam int PROG_BEATS = 200;
	localparam int SHORT_FRAMES = 24; // Single-beat frames around the long one.
	localparam int LONG_BEATS = 256; // Longest frame the accumulator covers.
	localparam int REPROG_BEATS = 120;
	localparam int TOTAL_BEATS = UNITY_BEATS + PROG_BEATS + SHORT_FRAMES + LONG_BEATS
		+ REPROG_BEATS;
	localparam int STIM_CYCLES = 2 * TOTAL_BEATS + 64; // Beats, gaps, writes and reset.
	localparam int WATCHDOG_NS = 4 * STIM_CYCLES * `TAP_REP * CLK_PERIOD;

	logic clk;
	logic rst;
	tapBeat_t inBeat;
	logic inValid;
	logic inReady;
	tapBeat_t fwdBeat;
	logic fwdValid;
	logic fwdReady;
	logic signed [`TAP_ACC_W-1:0] result;
	logic resValid;
	logic resReady;
	coefWrite_t coefWr;

	integer seed = 91; // Fixed seed for every random choice.
	logic bpOn; // Random back-pressure on both outputs.
	int fwdErrors;
	int resErrors;
	int otherErrors;
	int fwdLeft; // Forward beats the model still expects.
	int resLeft; // Results the model still expects.

	streamTapMac u_streamTapMac (
		.clk(clk),
		.rst(rst),
		.inBeat(inBeat),
		.inValid(inValid),
		.inReady(inReady),
		.fwdBeat(fwdBeat),
		.fwdValid(fwdValid),
		.fwdReady(fwdReady),
		.result(result),
		.resValid(resValid),
		.resReady(resReady),
		.coefWr(coefWr)
	);

	tapMacScoreboard scoreboard (
		.clk(clk),
		.rst(rst),
		.inBeat(inBeat),
		.inValid(inValid),
		.inReady(inReady),
		.fwdBeat(fwdBeat),
		.fwdValid(fwdValid),
		.fwdReady(fwdReady),
		.result(result),
		.resValid(resValid),
		.resReady(resReady),
		.coefWr(coefWr),
		.fwdErrors(fwdErrors),
		.resErrors(resErrors),
		.fwdLeft(fwdLeft),
		.resLeft(resLeft)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic int randBelow(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	// One clock step. Inputs change 0.5 ns after the edge, readies included.
	task automatic advance();
		@(posedge clk);
		#0.5;
		fwdReady = bpOn ? (randBelow(4) != 0) : 1'b1;
		resReady = bpOn ? (randBelow(2) != 0) : 1'b1;
	endtask

	// Offers one beat and holds it until the DUT takes it.
	task automatic sendBeat(input logic signed [`TAP_DATA_W-1:0] data, input logic last);
		logic taken;
		if (randBelow(4) == 0) begin
			advance(); // Idle gap on the input.
		end
		inBeat.data = data;
		inBeat.last = last;
		inValid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = inReady; // Settled here, so this edge transfers.
			advance();
		end
		inValid = 1'b0;
	endtask

	// Frame ends come at random. The final beat always closes a frame.
	task automatic sendRandomFrames(input int nBeats);
		for (int i = 0; i < nBeats; i++) begin
			sendBeat(`TAP_DATA_W'($random(seed)), (i == nBeats - 1) || (randBelow(5) == 0));
		end
	endtask

	task automatic sendFrame(input int len);
		for (int i = 0; i < len; i++) begin
			sendBeat(`TAP_DATA_W'($random(seed)), i == len - 1);
		end
	endtask

	// The model's queues only empty once the DUT has delivered everything.
	task automatic waitDrained();
		while (fwdLeft != 0 || resLeft != 0) begin
			advance();
		end
	endtask

	task automatic writeCoef(input int addr, input logic signed [`TAP_COEF_W-1:0] data);
		coefWr.we = 1'b1;
		coefWr.addr = `TAP_IDX_W'(addr);
		coefWr.data = data;
		advance();
		coefWr = '0;
	endtask

	// New random weights, plus a write to an unused address that must drop.
	task automatic programCoefs();
		for (int k = 0; k < `TAP_REP; k++) begin
			writeCoef(k, `TAP_COEF_W'($random(seed)));
		end
		if (`TAP_REP < (1 << `TAP_IDX_W)) begin
			writeCoef(`TAP_REP, `TAP_COEF_W'($random(seed)));
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns.", WATCHDOG_NS);
		$display("Errors: forward %0d, result %0d, other %0d", fwdErrors, resErrors,
			otherErrors);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		inBeat = '0;
		inValid = 1'b0;
		fwdReady = 1'b1;
		resReady = 1'b1;
		coefWr = '0;
		bpOn = 1'b0;
		otherErrors = 0;
		repeat (5) @(posedge clk);
		#0.5;
		rst = 1'b0;
		assert (inReady === 1'b1 && fwdValid === 1'b0 && resValid === 1'b0) else begin
			$display("Error at %0t ns: after reset inReady %b, fwdValid %b, resValid %b.",
				$time, inReady, fwdValid, resValid);
			otherErrors++;
		end
		sendRandomFrames(UNITY_BEATS); // Unity weights, no back-pressure.
		waitDrained();
		programCoefs();
		bpOn = 1'b1;
		sendRandomFrames(PROG_BEATS);
		waitDrained();
		for (int i = 0; i < SHORT_FRAMES / 2; i++) begin
			sendFrame(1);
		end
		sendFrame(LONG_BEATS);
		for (int i = 0; i < SHORT_FRAMES - SHORT_FRAMES / 2; i++) begin
			sendFrame(1); // The accumulator must start clean after the long frame.
		end
		waitDrained();
		programCoefs(); // Old weights must not leak into later results.
		sendRandomFrames(REPROG_BEATS);
		waitDrained();
		bpOn = 1'b0;
		repeat (4 * `TAP_REP) advance(); // Nothing more may come out.
		assert (fwdLeft == 0 && resLeft == 0 && !fwdValid && !resValid) else begin
			$display("At the end %0d forward beats and %0d results were still open.",
				fwdLeft, resLeft);
			$display("The DUT still offered a forward beat (%b) or a result (%b).",
				fwdValid, resValid);
			otherErrors++;
		end
		$display("Errors: forward %0d, result %0d, other %0d", fwdErrors, resErrors,
			otherErrors);
		if (fwdErrors + resErrors + otherErrors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule : tb_streamTapMac

`default_nettype wire

//--- project.f
+incdir+include
hw/tapMacPkg.sv
hw/streamTap.sv
hw/coefBank.sv
hw/macUnit.sv
hw/tapMacControl.sv
hw/streamTapMac.sv
verification/tapMacScoreboard.sv
verification/tb_streamTapMac.sv
